//--- dac_pkg.sv
package dac_pkg;

  // Colour cycle of a palette data access
  // Red, green and blue in turn, the fourth code never occurs
  typedef enum logic [1:0] {
    CYC_RED   = 2'd0,
    CYC_GREEN = 2'd1,
    CYC_BLUE  = 2'd2
  } dac_cycle_e;

  // I/O offsets inside the 3C6-3C9 block
  // Pixel mask at 3C6
  localparam logic [1:0] REG_MASK   = 2'd0;
  // Read index at 3C7, its read gives the DAC state
  localparam logic [1:0] REG_RINDEX = 2'd1;
  // Write index at 3C8
  localparam logic [1:0] REG_WINDEX = 2'd2;
  // Palette data at 3C9
  localparam logic [1:0] REG_DATA   = 2'd3;

  // Pixel mask after reset passes every index bit
  localparam logic [7:0] MASK_RESET = 8'hFF;

  // DAC state codes
  // Read index written last
  localparam logic [1:0] DAC_STATE_READ  = 2'b11;
  // Write index written last, also the reset state
  localparam logic [1:0] DAC_STATE_WRITE = 2'b00;

endpackage

//--- dac_bus_if.sv
`timescale 1ns/1ps

interface dac_bus_if #(
  parameter int COLOR_W = 8
) ();

  // Write side
  // One-cycle strobe, commits at the edge it is high
  logic                  write;
  dac_pkg::dac_cycle_e   write_cycle;
  logic [7:0]            write_register;
  logic [COLOR_W-1:0]    write_data;

  // Read side
  // read_data follows cycle and register one clock later
  dac_pkg::dac_cycle_e   read_cycle;
  logic [7:0]            read_register;
  logic [COLOR_W-1:0]    read_data;

  // Port controller side
  modport ctrl (
    output write, write_cycle, write_register, write_data,
    output read_cycle, read_register,
    input  read_data
  );

  // Palette storage side
  modport mem (
    input  write, write_cycle, write_register, write_data,
    input  read_cycle, read_register,
    output read_data
  );

endinterface

//--- dac_regs.sv
`timescale 1ns/1ps

module dac_regs #(
  parameter int COLOR_W = 8
) (
  input  logic               clk,

  // Display read port
  input  logic [7:0]         index,
  output logic [COLOR_W-1:0] red,
  output logic [COLOR_W-1:0] green,
  output logic [COLOR_W-1:0] blue,

  // CPU read and write ports
  dac_bus_if.mem             bus
);

  // Three colour tables, 256 entries each
  // contents undefined until the CPU loads them
  logic [COLOR_W-1:0] red_tab   [0:255];
  logic [COLOR_W-1:0] green_tab [0:255];
  logic [COLOR_W-1:0] blue_tab  [0:255];

  // Display read
  // One clock from index to colour
  always_ff @(posedge clk)
  begin
    red   <= red_tab[index];
    green <= green_tab[index];
    blue  <= blue_tab[index];
  end

  // CPU read
  // Table picked by the held read cycle
  always_ff @(posedge clk)
  begin
    case (bus.read_cycle)
      dac_pkg::CYC_RED:
        bus.read_data <= red_tab[bus.read_register];
      dac_pkg::CYC_GREEN:
        bus.read_data <= green_tab[bus.read_register];
      dac_pkg::CYC_BLUE:
        bus.read_data <= blue_tab[bus.read_register];
      // Unused code reads as zero
      default:
        bus.read_data <= '0;
    endcase
  end

  // CPU write
  // One colour per strobe, table picked by write cycle
  always_ff @(posedge clk)
  begin
    if (bus.write)
    begin
      case (bus.write_cycle)
        dac_pkg::CYC_RED:
          red_tab[bus.write_register] <= bus.write_data;
        dac_pkg::CYC_GREEN:
          green_tab[bus.write_register] <= bus.write_data;
        dac_pkg::CYC_BLUE:
          blue_tab[bus.write_register] <= bus.write_data;
        // Nothing stored for the unused code
        default:
        begin
        end
      endcase
    end
  end

endmodule

//--- dac_cpu_port.sv
`timescale 1ns/1ps

module dac_cpu_port #(
  parameter int COLOR_W = 8
) (
  input  logic       clk,
  input  logic       arst_n,

  // CPU strobes
  input  logic [1:0] io_addr,
  input  logic       io_wr,
  input  logic       io_rd,
  input  logic [7:0] io_wdata,
  output logic [7:0] io_rdata,

  // To the display path
  output logic [7:0] pixel_mask,

  // To the palette storage
  dac_bus_if.ctrl    bus
);

  // Index and cycle for each direction
  logic [7:0]          windex;
  logic [7:0]          rindex;
  dac_pkg::dac_cycle_e wcycle;
  dac_pkg::dac_cycle_e rcycle;

  // Pixel mask and DAC state
  logic [7:0]          mask;
  logic [1:0]          state;

  // Entry buffer, filled by data writes
  logic [COLOR_W-1:0]  buf_red;
  logic [COLOR_W-1:0]  buf_green;
  logic [COLOR_W-1:0]  buf_blue;

  // Entry commit sequencer
  logic                commit_busy;
  dac_pkg::dac_cycle_e commit_cycle;

  // Storage read data widened to a byte
  logic [7:0]          rd_ext;

  // Access decode
  logic                data_wr;
  logic                data_rd;

  // Red to green to blue and back
  function automatic dac_pkg::dac_cycle_e next_cycle(input dac_pkg::dac_cycle_e cyc);
    case (cyc)
      dac_pkg::CYC_RED:   next_cycle = dac_pkg::CYC_GREEN;
      dac_pkg::CYC_GREEN: next_cycle = dac_pkg::CYC_BLUE;
      default:            next_cycle = dac_pkg::CYC_RED;
    endcase
  endfunction

  assign data_wr = io_wr && (io_addr == dac_pkg::REG_DATA);
  assign data_rd = io_rd && (io_addr == dac_pkg::REG_DATA);
  assign rd_ext  = 8'(bus.read_data);

  // Buffered colours, low COLOR_W bits kept
  always_ff @(posedge clk)
  begin
    if (data_wr)
    begin
      case (wcycle)
        dac_pkg::CYC_RED:   buf_red   <= COLOR_W'(io_wdata);
        dac_pkg::CYC_GREEN: buf_green <= COLOR_W'(io_wdata);
        default:            buf_blue  <= COLOR_W'(io_wdata);
      endcase
    end
  end

  // Control state
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      windex       <= '0;
      rindex       <= '0;
      wcycle       <= dac_pkg::CYC_RED;
      rcycle       <= dac_pkg::CYC_RED;
      mask         <= dac_pkg::MASK_RESET;
      state        <= dac_pkg::DAC_STATE_WRITE;
      commit_busy  <= 1'b0;
      commit_cycle <= dac_pkg::CYC_RED;
      io_rdata     <= '0;
    end
    else
    begin
      // Commit runs red, green, blue then bumps the write index
      if (commit_busy)
      begin
        commit_cycle <= next_cycle(commit_cycle);
        if (commit_cycle == dac_pkg::CYC_BLUE)
        begin
          commit_busy <= 1'b0;
          windex      <= windex + 8'd1;
        end
      end

      if (io_wr)
      begin
        case (io_addr)
          dac_pkg::REG_MASK:
            mask <= io_wdata;
          // Held index and red cycle prime the storage read
          dac_pkg::REG_RINDEX:
          begin
            rindex <= io_wdata;
            rcycle <= dac_pkg::CYC_RED;
            state  <= dac_pkg::DAC_STATE_READ;
          end
          // Drops any half-sent triple
          dac_pkg::REG_WINDEX:
          begin
            windex <= io_wdata;
            wcycle <= dac_pkg::CYC_RED;
            state  <= dac_pkg::DAC_STATE_WRITE;
          end
          default:
          begin
            wcycle <= next_cycle(wcycle);
            // Blue completes the entry
            if (wcycle == dac_pkg::CYC_BLUE)
            begin
              commit_busy  <= 1'b1;
              commit_cycle <= dac_pkg::CYC_RED;
            end
          end
        endcase
      end

      if (io_rd)
      begin
        case (io_addr)
          dac_pkg::REG_MASK:   io_rdata <= mask;
          dac_pkg::REG_RINDEX: io_rdata <= {6'd0, state};
          dac_pkg::REG_WINDEX: io_rdata <= windex;
          default:             io_rdata <= rd_ext;
        endcase
      end

      // Step the read cycle, index moves on after blue
      if (data_rd)
      begin
        rcycle <= next_cycle(rcycle);
        if (rcycle == dac_pkg::CYC_BLUE)
          rindex <= rindex + 8'd1;
      end
    end
  end

  // Storage write from the buffer
  assign bus.write          = commit_busy;
  assign bus.write_cycle    = commit_cycle;
  assign bus.write_register = windex;
  assign bus.write_data     = (commit_cycle == dac_pkg::CYC_RED)   ? buf_red :
                              (commit_cycle == dac_pkg::CYC_GREEN) ? buf_green :
                                                                     buf_blue;

  // Storage read follows the held read pointer
  assign bus.read_cycle     = rcycle;
  assign bus.read_register  = rindex;

  assign pixel_mask         = mask;

endmodule

//--- dac_pixel_path.sv
`timescale 1ns/1ps

module dac_pixel_path #(
  parameter int COLOR_W = 8
) (
  input  logic               clk,
  input  logic               arst_n,

  // Pixel stream in
  input  logic [7:0]         pixel_index,
  input  logic               pixel_blank,
  input  logic [7:0]         pixel_mask,

  // Palette display port
  output logic [7:0]         lut_index,
  input  logic [COLOR_W-1:0] lut_red,
  input  logic [COLOR_W-1:0] lut_green,
  input  logic [COLOR_W-1:0] lut_blue,

  // Colour out
  output logic [COLOR_W-1:0] red,
  output logic [COLOR_W-1:0] green,
  output logic [COLOR_W-1:0] blue
);

  // Blank delay line, matches index register and palette read
  logic blank_d1;
  logic blank_d2;

  // Stage 1
  // Masked index into the palette
  always_ff @(posedge clk)
  begin
    lut_index <= pixel_index & pixel_mask;
  end

  // Blank follows its pixel through both stages
  // and the final stage zeroes the colour while blanked
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // Starts blanked so the outputs read zero
      blank_d1 <= 1'b1;
      blank_d2 <= 1'b1;
      red      <= '0;
      green    <= '0;
      blue     <= '0;
    end
    else
    begin
      blank_d1 <= pixel_blank;
      blank_d2 <= blank_d1;
      // Stage 3
      // Palette colour lands here two edges after the pixel
      red      <= blank_d2 ? '0 : lut_red;
      green    <= blank_d2 ? '0 : lut_green;
      blue     <= blank_d2 ? '0 : lut_blue;
    end
  end

endmodule

//--- vga_dac.sv
`timescale 1ns/1ps

module vga_dac #(
  parameter int COLOR_W = 8
) (
  input  logic               clk,
  input  logic               arst_n,

  // CPU side
  input  logic [1:0]         io_addr,
  input  logic               io_wr,
  input  logic               io_rd,
  input  logic [7:0]         io_wdata,
  output logic [7:0]         io_rdata,

  // Display side
  input  logic [7:0]         pixel_index,
  input  logic               pixel_blank,
  output logic [COLOR_W-1:0] red,
  output logic [COLOR_W-1:0] green,
  output logic [COLOR_W-1:0] blue
);

  // Mask from the register block to the pixel path
  logic [7:0]         pixel_mask;

  // Display port of the palette
  logic [7:0]         lut_index;
  logic [COLOR_W-1:0] lut_red;
  logic [COLOR_W-1:0] lut_green;
  logic [COLOR_W-1:0] lut_blue;

  // CPU palette accesses
  dac_bus_if #(.COLOR_W(COLOR_W)) bus ();

  // I/O register decode and entry buffer
  dac_cpu_port #(.COLOR_W(COLOR_W)) u_cpu_port (
    .clk        (clk),
    .arst_n     (arst_n),
    .io_addr    (io_addr),
    .io_wr      (io_wr),
    .io_rd      (io_rd),
    .io_wdata   (io_wdata),
    .io_rdata   (io_rdata),
    .pixel_mask (pixel_mask),
    .bus        (bus.ctrl)
  );

  // Palette tables
  dac_regs #(.COLOR_W(COLOR_W)) u_regs (
    .clk   (clk),
    .index (lut_index),
    .red   (lut_red),
    .green (lut_green),
    .blue  (lut_blue),
    .bus   (bus.mem)
  );

  // Mask, lookup and blank
  dac_pixel_path #(.COLOR_W(COLOR_W)) u_pixel_path (
    .clk         (clk),
    .arst_n      (arst_n),
    .pixel_index (pixel_index),
    .pixel_blank (pixel_blank),
    .pixel_mask  (pixel_mask),
    .lut_index   (lut_index),
    .lut_red     (lut_red),
    .lut_green   (lut_green),
    .lut_blue    (lut_blue),
    .red         (red),
    .green       (green),
    .blue        (blue)
  );

endmodule

//--- tb_vga_dac.sv
`timescale 1ns/1ps

module tb_vga_dac;

  localparam int          COLOR_W = 8;
  localparam logic [31:0] SEED    = 32'h20cc227e;
  localparam int          NUM_PIX = 300;

  // CPU and pixel accesses per test
  localparam int T1_ACC = 4;
  localparam int T2_ACC = 1540;
  localparam int T3_ACC = NUM_PIX;
  localparam int T4_ACC = NUM_PIX + 2;
  localparam int T5_ACC = NUM_PIX;
  localparam int T6_ACC = 15;
  localparam int WATCHDOG_CYCLES =
    4 * (T1_ACC + T2_ACC + T3_ACC + T4_ACC + T5_ACC + T6_ACC) + 1000;

  logic               clk;
  logic               arst_n;
  logic [1:0]         io_addr;
  logic               io_wr;
  logic               io_rd;
  logic [7:0]         io_wdata;
  logic [7:0]         io_rdata;
  logic [7:0]         pixel_index;
  logic               pixel_blank;
  logic [COLOR_W-1:0] red;
  logic [COLOR_W-1:0] green;
  logic [COLOR_W-1:0] blue;

  // Model palette and mask
  logic [COLOR_W-1:0] model_red   [0:255];
  logic [COLOR_W-1:0] model_green [0:255];
  logic [COLOR_W-1:0] model_blue  [0:255];
  logic [7:0]         mask_model;

  // Expected display colours, oldest first
  logic [3*COLOR_W-1:0] exp_q [$];

  logic        stream_on;
  logic        stream_rand_blank;
  logic [31:0] test_state;
  string       cur_test;
  int          error_count;
  int          check_count;

  vga_dac #(.COLOR_W(COLOR_W)) u_dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .io_addr     (io_addr),
    .io_wr       (io_wr),
    .io_rd       (io_rd),
    .io_wdata    (io_wdata),
    .io_rdata    (io_rdata),
    .pixel_index (pixel_index),
    .pixel_blank (pixel_blank),
    .red         (red),
    .green       (green),
    .blue        (blue)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Numerical Recipes LCG step
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected colour of one pixel, masked index and blank applied
  function automatic logic [3*COLOR_W-1:0] ref_pixel(input logic [7:0] idx,
                                                     input logic [7:0] mask,
                                                     input logic       blank);
    logic [7:0] eff;
    eff = idx & mask;
    if (blank)
      return '0;
    return {model_red[eff], model_green[eff], model_blue[eff]};
  endfunction

  task automatic rand_byte(output logic [7:0] v);
    test_state = lcg_next(test_state);
    v = test_state[31:24];
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_color(input string name,
                             input logic [COLOR_W-1:0] exp_r,
                             input logic [COLOR_W-1:0] exp_g,
                             input logic [COLOR_W-1:0] exp_b,
                             input logic [COLOR_W-1:0] act_r,
                             input logic [COLOR_W-1:0] act_g,
                             input logic [COLOR_W-1:0] act_b);
    check_count++;
    if (act_r !== exp_r || act_g !== exp_g || act_b !== exp_b)
    begin
      error_count++;
      $display("Mismatch in %s: expected %h/%h/%h, actual %h/%h/%h",
               name, exp_r, exp_g, exp_b, act_r, act_g, act_b);
    end
  endtask

  // One register write, then three idle cycles
  // Entered and left 2 ns after a rising edge
  task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
    io_addr  = addr;
    io_wdata = data;
    io_wr    = 1'b1;
    @(posedge clk);
    #2;
    io_wr = 1'b0;
    repeat (3) @(posedge clk);
    #2;
  endtask

  // io_rdata is loaded at the strobe edge
  task automatic read_reg(input logic [1:0] addr, output logic [7:0] data);
    io_addr = addr;
    io_rd   = 1'b1;
    @(posedge clk);
    #2;
    io_rd = 1'b0;
    data  = io_rdata;
    repeat (3) @(posedge clk);
    #2;
  endtask

  task automatic write_entry(input logic [7:0] idx, input logic [7:0] r,
                             input logic [7:0] g, input logic [7:0] b);
    write_reg(dac_pkg::REG_DATA, r);
    write_reg(dac_pkg::REG_DATA, g);
    write_reg(dac_pkg::REG_DATA, b);
    // Only the low bits are kept
    model_red[idx]   = COLOR_W'(r);
    model_green[idx] = COLOR_W'(g);
    model_blue[idx]  = COLOR_W'(b);
  endtask

  // Three data reads from the current read index
  task automatic verify_entry(input string name, input logic [7:0] idx);
    logic [7:0] v;
    read_reg(dac_pkg::REG_DATA, v);
    check_byte(name, 8'(model_red[idx]), v);
    read_reg(dac_pkg::REG_DATA, v);
    check_byte(name, 8'(model_green[idx]), v);
    read_reg(dac_pkg::REG_DATA, v);
    check_byte(name, 8'(model_blue[idx]), v);
  endtask

  // n random pixels, then drain the pipeline
  task automatic run_stream(input int n, input logic rand_blank);
    stream_rand_blank = rand_blank;
    stream_on         = 1'b1;
    repeat (n) @(posedge clk);
    #2;
    stream_on = 1'b0;
    repeat (3) @(posedge clk);
    #2;
  endtask

  // Pixel driver, one pixel per cycle
  // Blanked index 0 while no stream runs
  initial
  begin
    logic        on;
    logic        rb;
    logic [7:0]  mk;
    logic [31:0] pix_state;
    pixel_index = 8'h00;
    pixel_blank = 1'b1;
    pix_state   = SEED ^ 32'hffff_ffff;
    forever
    begin
      @(posedge clk);
      on = stream_on;
      rb = stream_rand_blank;
      mk = mask_model;
      #2;
      if (on)
      begin
        pix_state   = lcg_next(pix_state);
        pixel_index = pix_state[31:24];
        pixel_blank = rb ? pix_state[23] : 1'b0;
      end
      else
      begin
        pixel_index = 8'h00;
        pixel_blank = 1'b1;
      end
      exp_q.push_back(ref_pixel(pixel_index, mk, pixel_blank));
    end
  end

  // Display compare, two pixels stay in flight
  initial
  begin
    logic [3*COLOR_W-1:0] exp;
    forever
    begin
      @(posedge clk);
      #1;
      if (exp_q.size() > 2)
      begin
        exp = exp_q.pop_front();
        check_color({"display ", cur_test},
                    exp[3*COLOR_W-1:2*COLOR_W], exp[2*COLOR_W-1:COLOR_W], exp[COLOR_W-1:0],
                    red, green, blue);
      end
    end
  end

  // Watchdog
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Run timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    logic [7:0] w0;
    logic [7:0] idx;
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    logic [7:0] a;
    logic [7:0] data;
    io_addr           = 2'd0;
    io_wr             = 1'b0;
    io_rd             = 1'b0;
    io_wdata          = 8'h00;
    arst_n            = 1'b0;
    stream_on         = 1'b0;
    stream_rand_blank = 1'b0;
    mask_model        = dac_pkg::MASK_RESET;
    test_state        = SEED;
    error_count       = 0;
    check_count       = 0;
    cur_test          = "reset";
    // Outputs zero from reset before any blanked pixel reaches them
    @(posedge clk);
    #2;
    check_color("reset display", '0, '0, '0, red, green, blue);
    repeat (4) @(posedge clk);
    #2;
    arst_n = 1'b1;

    // Reset values
    read_reg(dac_pkg::REG_MASK, data);
    check_byte("reset mask", dac_pkg::MASK_RESET, data);
    read_reg(dac_pkg::REG_RINDEX, data);
    check_byte("reset state", {6'd0, dac_pkg::DAC_STATE_WRITE}, data);
    read_reg(dac_pkg::REG_WINDEX, data);
    check_byte("reset windex", 8'h00, data);

    // Full palette from a random start, wraps past 255
    cur_test = "palette load";
    rand_byte(w0);
    write_reg(dac_pkg::REG_WINDEX, w0);
    for (int i = 0; i < 256; i++)
    begin
      idx = w0 + 8'(i);
      rand_byte(r);
      rand_byte(g);
      rand_byte(b);
      write_entry(idx, r, g, b);
    end
    read_reg(dac_pkg::REG_WINDEX, data);
    check_byte("windex after wrap", w0, data);
    write_reg(dac_pkg::REG_RINDEX, w0);
    read_reg(dac_pkg::REG_RINDEX, data);
    check_byte("state after rindex", {6'd0, dac_pkg::DAC_STATE_READ}, data);
    for (int i = 0; i < 256; i++)
      verify_entry("palette readback", w0 + 8'(i));

    // Full mask, no blanking
    cur_test = "lookup";
    run_stream(NUM_PIX, 1'b0);

    // Random mask
    cur_test = "mask";
    rand_byte(a);
    write_reg(dac_pkg::REG_MASK, a);
    mask_model = a;
    read_reg(dac_pkg::REG_MASK, data);
    check_byte("mask readback", a, data);
    run_stream(NUM_PIX, 1'b0);

    // Random blank levels
    cur_test = "blank";
    run_stream(NUM_PIX, 1'b1);

    // Half triple dropped by a new write index
    cur_test = "abort";
    rand_byte(a);
    idx = a ^ 8'h55;
    rand_byte(r);
    rand_byte(g);
    write_reg(dac_pkg::REG_WINDEX, a);
    write_reg(dac_pkg::REG_DATA, r);
    write_reg(dac_pkg::REG_DATA, g);
    write_reg(dac_pkg::REG_WINDEX, idx);
    rand_byte(r);
    rand_byte(g);
    rand_byte(b);
    write_entry(idx, r, g, b);
    write_reg(dac_pkg::REG_RINDEX, idx);
    verify_entry("new entry", idx);
    write_reg(dac_pkg::REG_RINDEX, a);
    verify_entry("old entry", a);

    repeat (3) @(posedge clk);
    #2;
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- vga_dac.f
dac_pkg.sv
dac_bus_if.sv
dac_regs.sv
dac_cpu_port.sv
dac_pixel_path.sv
vga_dac.sv
tb_vga_dac.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the palette DAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_vga_dac -f vga_dac.f -o sim_vga_dac; then
  echo "Compilation failed"
  exit 1
fi

out=$(./obj_dir/sim_vga_dac)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only when the testbench printed its pass line
if echo "$out" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1
